// ==== common/uart_defines.svh ====
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Width of the AXI4-Lite address bus.
// Only the low nibble is decoded.
`define UART_ADDR_W 4

// Width of the AXI4-Lite data bus.
`define UART_DATA_W 32

// Word offsets of the three registers.
// CTRL holds the configuration, STATUS the flags, RXDATA the character.
`define UART_CTRL_OFS   4'h0
`define UART_STATUS_OFS 4'h4
`define UART_RXDATA_OFS 4'h8

// Bit positions inside the STATUS word.
// Writing 1 to the error bit clears the sticky error.
`define UART_ST_BUSY  0
`define UART_ST_ERR   1
`define UART_ST_VALID 2

`endif

// ==== common/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // States of the receive FSM.
  // One frame walks through them in this order, PARITY only when enabled.
  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
  } rx_state_e;

  // Field view of the CTRL word.
  // The first member sits at the top of the word.
  // One bit lasts div+1 clock cycles.
  // Codes 0 to 3 in bits_code select 5 to 8 data bits.
  typedef struct packed {
    logic [11:0] rsvd;
    logic [1:0]  bits_code;
    logic        parity_en;
    logic        en;
    logic [15:0] div;
  } uart_cfg_t;

  // The CTRL word as the bus sees it and as the receiver sees it.
  typedef union packed {
    logic [31:0] raw;
    uart_cfg_t   cfg;
  } uart_ctrl_u;

endpackage

`default_nettype wire

// ==== hw/uart_axil_regs.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "uart_defines.svh"

module uart_axil_regs import uart_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    rstn_i,
  input  wire logic [`UART_ADDR_W-1:0] awaddr_i,
  input  wire logic                    awvalid_i,
  output logic                         awready_o,
  input  wire logic [`UART_DATA_W-1:0] wdata_i,
  input  wire logic                    wvalid_i,
  output logic                         wready_o,
  output logic                         bvalid_o,
  input  wire logic                    bready_i,
  output logic [1:0]                   bresp_o,
  input  wire logic [`UART_ADDR_W-1:0] araddr_i,
  input  wire logic                    arvalid_i,
  output logic                         arready_o,
  output logic                         rvalid_o,
  input  wire logic                    rready_i,
  output logic [`UART_DATA_W-1:0]      rdata_o,
  output logic [1:0]                   rresp_o,
  output uart_cfg_t                    cfg_o,
  output logic                         rd_pop_o,
  output logic                         err_clr_o,
  input  wire logic                    busy_i,
  input  wire logic                    rx_valid_i,
  input  wire logic                    err_i,
  input  wire logic [7:0]              rx_data_i
);

  uart_ctrl_u             ctrl_q;
  logic                   wr_fire;
  logic                   rd_fire;
  logic [`UART_DATA_W-1:0] rd_word;

  // A pending response blocks the next request on the same channel.
  assign awready_o = ~bvalid_o;
  assign wready_o  = ~bvalid_o;
  assign arready_o = ~rvalid_o;

  // Address and data must arrive together, there is no buffering of either.
  assign wr_fire = awvalid_i & wvalid_i & awready_o & wready_o;
  assign rd_fire = arvalid_i & arready_o;

  // Every access completes with OKAY.
  assign bresp_o = 2'b00;
  assign rresp_o = 2'b00;

  // Both side effects last exactly the cycle in which the request is taken.
  assign rd_pop_o  = rd_fire & (araddr_i == `UART_RXDATA_OFS);
  assign err_clr_o = wr_fire & (awaddr_i == `UART_STATUS_OFS) & wdata_i[`UART_ST_ERR];

  // The receiver only ever sees the decoded fields of CTRL.
  assign cfg_o = ctrl_q.cfg;

  // Read multiplexer.
  // An unmapped offset reads as zero.
  always_comb begin
    rd_word = '0;
    case (araddr_i)
      `UART_CTRL_OFS: rd_word = ctrl_q.raw;
      `UART_STATUS_OFS: begin
        rd_word[`UART_ST_BUSY]  = busy_i;
        rd_word[`UART_ST_ERR]   = err_i;
        rd_word[`UART_ST_VALID] = rx_valid_i;
      end
      `UART_RXDATA_OFS: rd_word = {{(`UART_DATA_W-8){1'b0}}, rx_data_i};
      default: rd_word = '0;
    endcase
  end

  // Write channel.
  // CTRL is stored whole, reserved bits included, so it reads back as written.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      ctrl_q.raw <= '0;
      bvalid_o   <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_o <= 1'b1;
        if (awaddr_i == `UART_CTRL_OFS) begin
          ctrl_q.raw <= wdata_i;
        end
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
    end
  end

  // Read channel valid flag.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rvalid_o <= 1'b0;
    end else if (rd_fire) begin
      rvalid_o <= 1'b1;
    end else if (rready_i) begin
      rvalid_o <= 1'b0;
    end
  end

  // Read data is captured once and then held while the master stalls.
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_o <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx/uart_rx_fsm.sv ====
`default_nettype none
`timescale 1ns/100ps

module uart_rx_fsm import uart_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rstn_i,
  input  wire uart_cfg_t cfg_i,
  input  wire logic      rx_fall_i,
  input  wire logic      rx_sync_i,
  input  wire logic      bit_tick_i,
  input  wire logic      last_bit_i,
  output logic           timer_run_o,
  output logic           half_bit_o,
  output logic           shift_en_o,
  output logic           sample_parity_o,
  output logic           sample_stop_o,
  output logic           commit_o,
  output logic           busy_o
);

  rx_state_e state_q;
  rx_state_e state_d;

  // The timer runs for the whole frame.
  // Only the start bit uses the half period, so later samples land mid-bit.
  assign timer_run_o = (state_q != IDLE);
  assign half_bit_o  = (state_q == START);
  assign busy_o      = (state_q != IDLE);

  // Each strobe is one bit tick qualified by the bit it belongs to.
  assign shift_en_o      = bit_tick_i & (state_q == DATA);
  assign sample_parity_o = bit_tick_i & (state_q == PARITY);
  assign sample_stop_o   = bit_tick_i & (state_q == STOP);

  // The character is handed over on the stop bit tick, good stop bit or not.
  assign commit_o = bit_tick_i & (state_q == STOP);

  // Next state logic.
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (rx_fall_i) begin
          state_d = START;
        end
      end
      START: begin
        // A line that is high again at mid-bit was only a glitch.
        if (bit_tick_i) begin
          state_d = rx_sync_i ? IDLE : DATA;
        end
      end
      DATA: begin
        if (bit_tick_i && last_bit_i) begin
          state_d = cfg_i.parity_en ? PARITY : STOP;
        end
      end
      PARITY: begin
        if (bit_tick_i) begin
          state_d = STOP;
        end
      end
      STOP: begin
        if (bit_tick_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // State register.
  // Disabling the receiver abandons any frame in progress.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= IDLE;
    end else if (!cfg_i.en) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx/uart_baud_timer.sv ====
`default_nettype none
`timescale 1ns/100ps

module uart_baud_timer (
  input  wire logic        clk_i,
  input  wire logic        rstn_i,
  input  wire logic [15:0] div_i,
  input  wire logic        run_i,
  input  wire logic        half_i,
  output logic             tick_o
);

  logic [15:0] cnt_q;
  logic [15:0] target;

  // Half a bit for the start bit, a full bit for the rest.
  assign target = half_i ? {1'b0, div_i[15:1]} : div_i;

  // The tick is registered together with the reload.
  // So the first tick comes div/2+1 cycles after run rises, later ones div+1 apart.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (!run_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (cnt_q == target) begin
      cnt_q  <= '0;
      tick_o <= 1'b1;
    end else begin
      cnt_q  <= cnt_q + 16'd1;
      tick_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx/uart_rx_shifter.sv ====
`default_nettype none
`timescale 1ns/100ps

module uart_rx_shifter import uart_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rstn_i,
  input  wire uart_cfg_t cfg_i,
  input  wire logic      rx_i,
  output logic           rx_sync_o,
  output logic           rx_fall_o,
  input  wire logic      shift_en_i,
  input  wire logic      sample_parity_i,
  input  wire logic      sample_stop_i,
  input  wire logic      commit_i,
  input  wire logic      pop_i,
  input  wire logic      err_clr_i,
  output logic           last_bit_o,
  output logic [7:0]     rx_data_o,
  output logic           rx_valid_o,
  output logic           err_o
);

  logic [2:0] sync_q;
  logic       prev_q;
  logic [2:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic       par_q;
  logic       full;
  logic       set_err;

  // Three flops before the line is used; the idle level is high.
  assign rx_sync_o = sync_q[2];
  assign rx_fall_o = prev_q & ~sync_q[2];

  // Bit index 4+code is the last one, so codes 0 to 3 give 5 to 8 bits.
  assign last_bit_o = (bit_cnt_q == {1'b1, cfg_i.bits_code});

  // A pop in the commit cycle frees the holding register in time.
  assign full = rx_valid_o & ~pop_i;

  // Parity mismatch, low stop bit and overrun all land in one sticky flag.
  assign set_err = (sample_parity_i & (par_q != sync_q[2])) |
                   (sample_stop_i & ~sync_q[2]) |
                   (commit_i & full);

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      sync_q     <= 3'b111;
      prev_q     <= 1'b1;
      bit_cnt_q  <= '0;
      rx_valid_o <= 1'b0;
      err_o      <= 1'b0;
    end else if (!cfg_i.en) begin
      sync_q     <= 3'b111;
      prev_q     <= 1'b1;
      bit_cnt_q  <= '0;
      rx_valid_o <= 1'b0;
      err_o      <= 1'b0;
    end else begin
      sync_q <= {sync_q[1:0], rx_i};
      prev_q <= sync_q[2];
      if (shift_en_i) begin
        bit_cnt_q <= last_bit_o ? 3'd0 : bit_cnt_q + 3'd1;
      end
      // On overrun the old character stays.
      if (commit_i && !full) begin
        rx_valid_o <= 1'b1;
      end else if (pop_i) begin
        rx_valid_o <= 1'b0;
      end
      // A new error wins over a clear in the same cycle.
      if (set_err) begin
        err_o <= 1'b1;
      end else if (err_clr_i) begin
        err_o <= 1'b0;
      end
    end
  end

  // Bits enter at the top, LSB first, and parity restarts with bit zero.
  always_ff @(posedge clk_i) begin
    if (shift_en_i) begin
      shift_q <= {sync_q[2], shift_q[7:1]};
      par_q   <= (bit_cnt_q == 3'd0) ? sync_q[2] : (par_q ^ sync_q[2]);
    end
    if (commit_i && !full) begin
      rx_data_o <= shift_q >> (2'd3 - cfg_i.bits_code);
    end
  end

endmodule

`default_nettype wire

// ==== hw/uart_rx_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "uart_defines.svh"

module uart_rx_top import uart_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    rstn_i,
  input  wire logic                    rx_i,
  input  wire logic [`UART_ADDR_W-1:0] awaddr_i,
  input  wire logic                    awvalid_i,
  output logic                         awready_o,
  input  wire logic [`UART_DATA_W-1:0] wdata_i,
  input  wire logic                    wvalid_i,
  output logic                         wready_o,
  output logic                         bvalid_o,
  input  wire logic                    bready_i,
  output logic [1:0]                   bresp_o,
  input  wire logic [`UART_ADDR_W-1:0] araddr_i,
  input  wire logic                    arvalid_i,
  output logic                         arready_o,
  output logic                         rvalid_o,
  input  wire logic                    rready_i,
  output logic [`UART_DATA_W-1:0]      rdata_o,
  output logic [1:0]                   rresp_o
);

  uart_cfg_t  cfg;
  logic       rd_pop, err_clr, busy, rx_valid, err;
  logic [7:0] rx_data;
  logic       timer_run, half_bit, bit_tick;
  logic       shift_en, sample_parity, sample_stop, commit;
  logic       rx_sync, rx_fall, last_bit;

  // Bus side, configuration and status.
  uart_axil_regs u_regs (
    .clk_i, .rstn_i, .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wvalid_i, .wready_o,
    .bvalid_o, .bready_i, .bresp_o, .araddr_i, .arvalid_i, .arready_o, .rvalid_o,
    .rready_i, .rdata_o, .rresp_o, .cfg_o(cfg), .rd_pop_o(rd_pop), .err_clr_o(err_clr),
    .busy_i(busy), .rx_valid_i(rx_valid), .err_i(err), .rx_data_i(rx_data)
  );

  // Frame sequencing.
  uart_rx_fsm u_fsm (
    .clk_i, .rstn_i, .cfg_i(cfg), .rx_fall_i(rx_fall), .rx_sync_i(rx_sync),
    .bit_tick_i(bit_tick), .last_bit_i(last_bit), .timer_run_o(timer_run),
    .half_bit_o(half_bit), .shift_en_o(shift_en), .sample_parity_o(sample_parity),
    .sample_stop_o(sample_stop), .commit_o(commit), .busy_o(busy)
  );

  uart_baud_timer u_timer (
    .clk_i, .rstn_i, .div_i(cfg.div), .run_i(timer_run), .half_i(half_bit),
    .tick_o(bit_tick)
  );

  // Serial datapath and holding register.
  uart_rx_shifter u_shifter (
    .clk_i, .rstn_i, .cfg_i(cfg), .rx_i, .rx_sync_o(rx_sync), .rx_fall_o(rx_fall),
    .shift_en_i(shift_en), .sample_parity_i(sample_parity), .sample_stop_i(sample_stop),
    .commit_i(commit), .pop_i(rd_pop), .err_clr_i(err_clr), .last_bit_o(last_bit),
    .rx_data_o(rx_data), .rx_valid_o(rx_valid), .err_o(err)
  );

endmodule

`default_nettype wire

// ==== verification/uart_rx_chk.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "uart_defines.svh"

module uart_rx_chk import uart_pkg::*; (
  input wire logic                    clk_i,
  input wire logic                    rstn_i,
  input wire logic                    bvalid_i,
  input wire logic                    bready_i,
  input wire logic                    rvalid_i,
  input wire logic                    rready_i,
  input wire logic [`UART_DATA_W-1:0] rdata_i,
  input wire uart_cfg_t               cfg_i,
  input wire logic                    busy_i
);

  // A write response must stay up until the master takes it.
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid_o dropped before bready_i");

  // The same holds for read data, which must not change while it waits.
  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid_o dropped before rready_i");

  a_rdata_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    rvalid_i && !rready_i |=> $stable(rdata_i))
    else $error("rdata_o changed while rvalid_o waited");

  // Disabling the receiver abandons the frame within one cycle.
  a_busy_off: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !cfg_i.en |=> !busy_i)
    else $error("busy still high one cycle after en dropped");

endmodule

bind uart_rx_top uart_rx_chk u_chk (
  .clk_i(clk_i), .rstn_i(rstn_i), .bvalid_i(bvalid_o), .bready_i(bready_i),
  .rvalid_i(rvalid_o), .rready_i(rready_i), .rdata_i(rdata_o), .cfg_i(cfg),
  .busy_i(busy)
);

`default_nettype wire

// ==== verification/uart_rx_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "uart_defines.svh"

module uart_rx_tb import uart_pkg::*; ();

  // One bit lasts div+1 cycles, with div at 15.
  localparam logic [15:0] DIV      = 16'd15;
  localparam int          BIT_CYC  = 16;
  // Limits on one bus handshake and on one STATUS poll loop.
  localparam int          HS_MAX   = 64;
  localparam int          POLL_MAX = 200;

  logic                    clk_i;
  logic                    rstn_i;
  logic                    rx_i;
  logic [`UART_ADDR_W-1:0] awaddr_i;
  logic                    awvalid_i;
  logic                    awready_o;
  logic [`UART_DATA_W-1:0] wdata_i;
  logic                    wvalid_i;
  logic                    wready_o;
  logic                    bvalid_o;
  logic                    bready_i;
  logic [1:0]              bresp_o;
  logic [`UART_ADDR_W-1:0] araddr_i;
  logic                    arvalid_i;
  logic                    arready_o;
  logic                    rvalid_o;
  logic                    rready_i;
  logic [`UART_DATA_W-1:0] rdata_o;
  logic [1:0]              rresp_o;

  integer seed;
  int     checks;
  int     errors;

  uart_rx_top u_dut (
    .clk_i, .rstn_i, .rx_i, .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wvalid_i,
    .wready_o, .bvalid_o, .bready_i, .bresp_o, .araddr_i, .arvalid_i, .arready_o,
    .rvalid_o, .rready_i, .rdata_o, .rresp_o
  );

  always #4 clk_i = ~clk_i;

  // Expected RXDATA: the sent value cut to the bit count, zero-extended.
  function automatic logic [`UART_DATA_W-1:0] exp_rxdata(input logic [7:0] data,
                                                         input int nbits);
    logic [7:0] mask;
    mask = 8'hff >> (8 - nbits);
    return {{(`UART_DATA_W-8){1'b0}}, data & mask};
  endfunction

  // CTRL word with div 15 and the chosen format.
  function automatic logic [`UART_DATA_W-1:0] make_ctrl(input logic [1:0] code,
                                                        input logic par_en, input logic en);
    uart_ctrl_u ctrl;
    ctrl.raw           = '0;
    ctrl.cfg.div       = DIV;
    ctrl.cfg.en        = en;
    ctrl.cfg.parity_en = par_en;
    ctrl.cfg.bits_code = code;
    return ctrl.raw;
  endfunction

  // Ends the run after a wait that never completed.
  task automatic abort_run(input string why);
    $display("Timeout, %s", why);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic check_word(input logic [`UART_DATA_W-1:0] got,
                            input logic [`UART_DATA_W-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Address and data go out together; readiness is judged at the falling edge.
  task automatic axi_write(input logic [`UART_ADDR_W-1:0] addr,
                           input logic [`UART_DATA_W-1:0] data);
    int n;
    @(posedge clk_i);
    awaddr_i  <= addr;
    wdata_i   <= data;
    awvalid_i <= 1'b1;
    wvalid_i  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(awready_o && wready_o) && n < HS_MAX);
    if (!(awready_o && wready_o)) abort_run("write address and data never accepted");
    @(posedge clk_i);
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!bvalid_o && n < HS_MAX);
    if (!bvalid_o) abort_run("no write response arrived");
    check_resp(bresp_o, 2'b00, "BRESP");
    check_flag(awready_o || wready_o, 1'b0, "write ready while BVALID waits");
    // The response is held back one cycle so that BVALID has to wait.
    @(posedge clk_i);
    bready_i <= 1'b1;
    @(posedge clk_i);
    bready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [`UART_ADDR_W-1:0] addr,
                          output logic [`UART_DATA_W-1:0] data);
    int n;
    @(posedge clk_i);
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!arready_o && n < HS_MAX);
    if (!arready_o) abort_run("read address never accepted");
    @(posedge clk_i);
    arvalid_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!rvalid_o && n < HS_MAX);
    if (!rvalid_o) abort_run("no read data arrived");
    check_resp(rresp_o, 2'b00, "RRESP");
    check_flag(arready_o, 1'b0, "ARREADY while RVALID waits");
    data = rdata_o;
    // The read data waits one cycle before the master takes it.
    @(posedge clk_i);
    rready_i <= 1'b1;
    @(posedge clk_i);
    rready_i <= 1'b0;
  endtask

  // Each bit holds the line for a full bit period from one rising edge.
  task automatic send_bit(input logic b);
    rx_i <= b;
    repeat (BIT_CYC) @(posedge clk_i);
  endtask

  // Even parity makes the parity bit the XOR of the data bits.
  task automatic serial_send(input logic [7:0] data, input int nbits, input logic par_en,
                             input logic par_ok, input logic stop);
    logic par;
    par = ^(data & (8'hff >> (8 - nbits)));
    @(posedge clk_i);
    send_bit(1'b1);
    send_bit(1'b0);
    for (int i = 0; i < nbits; i++) begin
      send_bit(data[i]);
    end
    if (par_en) send_bit(par_ok ? par : ~par);
    send_bit(stop);
    rx_i <= 1'b1;
  endtask

  task automatic wait_status(input int pos, input logic val, input string what);
    logic [`UART_DATA_W-1:0] st;
    int n;
    n = 0;
    do begin
      axi_read(`UART_STATUS_OFS, st);
      n++;
    end while (st[pos] !== val && n < POLL_MAX);
    if (st[pos] !== val) abort_run({"STATUS never showed ", what});
  endtask

  // Collects one character and checks the flags around it.
  task automatic expect_frame(input logic [7:0] ch, input int nbits, input logic exp_err);
    logic [`UART_DATA_W-1:0] rd;
    wait_status(`UART_ST_VALID, 1'b1, "data valid");
    axi_read(`UART_STATUS_OFS, rd);
    check_flag(rd[`UART_ST_ERR], exp_err, "STATUS error");
    axi_read(`UART_RXDATA_OFS, rd);
    check_word(rd, exp_rxdata(ch, nbits), "RXDATA");
    axi_read(`UART_STATUS_OFS, rd);
    check_flag(rd[`UART_ST_VALID], 1'b0, "STATUS valid after read");
  endtask

  initial begin
    logic [`UART_DATA_W-1:0] rd;
    logic [`UART_DATA_W-1:0] wr;
    logic [7:0]              ch;
    logic [7:0]              ch2;
    seed      = 32'hc58e;
    checks    = 0;
    errors    = 0;
    clk_i     = 1'b0;
    rstn_i    = 1'b0;
    rx_i      = 1'b1;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    repeat (10) @(posedge clk_i);
    rstn_i <= 1'b1;

    // Reset state and CTRL readback, with an unmapped offset reading zero.
    axi_read(`UART_STATUS_OFS, rd);
    check_word(rd, '0, "STATUS after reset");
    wr = $random(seed);
    axi_write(`UART_CTRL_OFS, wr);
    axi_read(`UART_CTRL_OFS, rd);
    check_word(rd, wr, "CTRL readback");
    axi_read(4'hc, rd);
    check_word(rd, '0, "unmapped read");

    // Eight data bits, no parity.
    axi_write(`UART_CTRL_OFS, make_ctrl(2'd3, 1'b0, 1'b1));
    repeat (4) begin
      ch = 8'($random(seed));
      serial_send(ch, 8, 1'b0, 1'b1, 1'b1);
      expect_frame(ch, 8, 1'b0);
    end

    // Five, six and seven data bits.
    for (int code = 0; code < 3; code++) begin
      axi_write(`UART_CTRL_OFS, make_ctrl(2'(code), 1'b0, 1'b1));
      ch = 8'($random(seed));
      serial_send(ch, 5 + code, 1'b0, 1'b1, 1'b1);
      expect_frame(ch, 5 + code, 1'b0);
    end

    // Parity good, then bad, then the error is cleared by software.
    axi_write(`UART_CTRL_OFS, make_ctrl(2'd3, 1'b1, 1'b1));
    ch = 8'($random(seed));
    serial_send(ch, 8, 1'b1, 1'b1, 1'b1);
    expect_frame(ch, 8, 1'b0);
    ch = 8'($random(seed));
    serial_send(ch, 8, 1'b1, 1'b0, 1'b1);
    expect_frame(ch, 8, 1'b1);
    axi_write(`UART_STATUS_OFS, 32'd1 << `UART_ST_ERR);
    axi_read(`UART_STATUS_OFS, rd);
    check_flag(rd[`UART_ST_ERR], 1'b0, "STATUS error after clear");

    // A low stop bit is a framing error.
    axi_write(`UART_CTRL_OFS, make_ctrl(2'd3, 1'b0, 1'b1));
    ch = 8'($random(seed));
    serial_send(ch, 8, 1'b0, 1'b1, 1'b0);
    expect_frame(ch, 8, 1'b1);
    axi_write(`UART_STATUS_OFS, 32'd1 << `UART_ST_ERR);

    // Overrun keeps the first character.
    ch  = 8'($random(seed));
    ch2 = 8'($random(seed));
    serial_send(ch, 8, 1'b0, 1'b1, 1'b1);
    serial_send(ch2, 8, 1'b0, 1'b1, 1'b1);
    wait_status(`UART_ST_ERR, 1'b1, "overrun error");
    axi_read(`UART_RXDATA_OFS, rd);
    check_word(rd, exp_rxdata(ch, 8), "RXDATA after overrun");
    axi_write(`UART_STATUS_OFS, 32'd1 << `UART_ST_ERR);
    axi_read(`UART_STATUS_OFS, rd);
    check_word(rd, '0, "STATUS after overrun clear");

    // Dropping en in the middle of a frame abandons it.
    fork
      serial_send(8'($random(seed)), 8, 1'b0, 1'b1, 1'b1);
      begin
        repeat (4 * BIT_CYC) @(posedge clk_i);
        axi_write(`UART_CTRL_OFS, make_ctrl(2'd3, 1'b0, 1'b0));
      end
    join
    axi_read(`UART_STATUS_OFS, rd);
    check_word(rd, '0, "STATUS after disable mid-frame");

    // A disabled receiver ignores the line.
    serial_send(8'($random(seed)), 8, 1'b0, 1'b1, 1'b1);
    axi_read(`UART_STATUS_OFS, rd);
    check_flag(rd[`UART_ST_VALID], 1'b0, "STATUS valid while disabled");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/uart_pkg.sv
hw/uart_axil_regs.sv
uart_rx/uart_rx_fsm.sv
uart_rx/uart_baud_timer.sv
uart_rx/uart_rx_shifter.sv
hw/uart_rx_top.sv
verification/uart_rx_chk.sv
verification/uart_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f vlog.f --top-module uart_rx_tb -o uart_rx_sim &&
  ./obj_dir/uart_rx_sim | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
